/* scalarmult_sched.f */
src/ed_sched_pkg.sv
src/scalar_recoder.sv
src/digit_bank.sv
src/ladder_sequencer.sv
src/scalarmult_sched_top.sv
verification/tb_scalarmult_sched.sv

/* Makefile */
TOP = tb_scalarmult_sched
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		--top-module $(TOP) -Mdir obj_dir -f scalarmult_sched.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/tb_scalarmult_sched.sv */
`timescale 1ns/1ns

module tb_scalarmult_sched;
    import ed_sched_pkg::*;

    localparam int RUN_LIMIT = 20000;   // Cycles per run, long delays included

    logic    clk;
    logic    reset;
    logic    start;
    scalar_t scalar;
    logic    op_done;
    logic    op_valid;
    op_t     op;
    pos_t    op_pos;
    digit_t  op_digit;
    logic    busy;
    logic    done;

    logic    resp_done = 1'b0;   // Completion from the point unit model
    logic    resp_busy = 1'b0;
    int      resp_wait = 0;
    int      delay_pick;
    logic    spur_done;          // Stray completions while nothing is outstanding
    int      delay_mode;         // 0 short random, 1 zero, 2 long
    string   test_name;

    op_t     exp_op    [N_COMMANDS];
    pos_t    exp_pos   [N_COMMANDS];
    digit_t  exp_digit [N_COMMANDS];
    int      n_exp;
    int      cmd_cnt;
    int      done_cnt;
    int      chk_errors;
    int      errors;
    int      tests;
    int      failed;
    logic    outstanding;
    logic    resp_done_d;

    assign op_done = resp_done | spur_done;

    scalarmult_sched_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .scalar   (scalar),
        .op_done  (op_done),
        .op_valid (op_valid),
        .op       (op),
        .op_pos   (op_pos),
        .op_digit (op_digit),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic void add_cmd(input op_t o, input int pos, input int digit);
        exp_op[n_exp]    = o;
        exp_pos[n_exp]   = pos_t'(pos);
        exp_digit[n_exp] = digit_t'(digit);
        n_exp++;
    endfunction

    // Expected command stream for one scalar
    function automatic void build_expected(input scalar_t s);
        int digits [N_DIGITS];
        int carry;
        int sum;
        carry = 0;
        for (int j = 0; j < N_DIGITS; j++) begin
            sum = int'(s[j*NIBBLE_W +: NIBBLE_W]) + carry;
            if (j < N_DIGITS - 1 && sum >= 8) begin
                digits[j] = sum - 16;
                carry     = 1;
            end else begin
                digits[j] = sum;   // Top digit keeps the carry
                carry     = 0;
            end
        end
        n_exp = 0;
        add_cmd(OP_SET_NEUTRAL, 0, 0);
        for (int i = 1; i < N_DIGITS; i += 2) begin
            add_cmd(OP_MADD, i / 2, digits[i]);
            add_cmd(OP_TO_P3, 0, 0);
        end
        for (int k = 0; k < N_DOUBLINGS; k++) begin
            add_cmd((k == 0) ? OP_P3_DBL : OP_P2_DBL, 0, 0);
            add_cmd((k == N_DOUBLINGS - 1) ? OP_TO_P3 : OP_TO_P2, 0, 0);
        end
        for (int i = 0; i < N_DIGITS; i += 2) begin
            add_cmd(OP_MADD, i / 2, digits[i]);
            add_cmd(OP_TO_P3, 0, 0);
        end
    endfunction

    function automatic scalar_t random_scalar();
        scalar_t s;
        for (int w = 0; w < $bits(scalar_t) / 32; w++) begin
            s[w*32 +: 32] = $urandom();
        end
        s[$bits(scalar_t)-1] = 1'b0;   // Recoder needs bit 255 clear
        return s;
    endfunction

    function automatic int pick_delay();
        case (delay_mode)
            1:       return 0;
            2:       return $urandom_range(40, 20);
            default: return $urandom_range(6, 0);
        endcase
    endfunction

    // Point unit model
    always @(posedge clk) begin
        resp_done <= 1'b0;
        if (!reset) begin
            resp_busy <= 1'b0;
            resp_wait <= 0;
        end else if (op_valid) begin
            delay_pick = pick_delay();
            resp_done <= (delay_pick == 0);
            resp_busy <= (delay_pick != 0);
            resp_wait <= delay_pick;
        end else if (resp_busy) begin
            if (resp_wait == 1) begin
                resp_done <= 1'b1;
                resp_busy <= 1'b0;
            end
            resp_wait <= resp_wait - 1;
        end
    end

    task automatic check_value(input string what, input int idx, input int expv, input int actv);
        assert (expv == actv) else begin
            $display("ERR %s cmd %0d %s: expected %0d, actual %0d",
                     test_name, idx, what, expv, actv);
            chk_errors++;
        end
    endtask

    // Compares every command as it is issued
    always @(posedge clk) begin
        if (!reset || (start && !busy)) begin
            cmd_cnt     = 0;
            done_cnt    = 0;
            outstanding = 1'b0;
        end else begin
            if (op_valid) begin
                assert (!outstanding) else begin
                    $display("%s: command %0d issued before the previous op_done",
                             test_name, cmd_cnt);
                    chk_errors++;
                end
                assert (cmd_cnt < n_exp) else begin
                    $display("%s: more than %0d commands issued", test_name, n_exp);
                    chk_errors++;
                end
                if (cmd_cnt < n_exp) begin
                    check_value("op", cmd_cnt, int'(exp_op[cmd_cnt]), int'(op));
                    check_value("pos", cmd_cnt, int'(exp_pos[cmd_cnt]), int'(op_pos));
                    check_value("digit", cmd_cnt, int'(exp_digit[cmd_cnt]), int'(op_digit));
                end
                outstanding = 1'b1;
                cmd_cnt++;
            end else if (resp_done) begin
                outstanding = 1'b0;
            end
            if (done) begin
                done_cnt++;
                assert (cmd_cnt == n_exp && !outstanding && resp_done_d) else begin
                    $display("%s: done pulsed before the last command completed", test_name);
                    chk_errors++;
                end
            end
        end
        resp_done_d = resp_done;
    end

    task automatic report(input string name, input int errs_before);
        tests++;
        if (errors + chk_errors == errs_before) begin
            $display("test %s passed with %0d commands", name, cmd_cnt);
        end else begin
            failed++;
            $display("test %s failed", name);
        end
    endtask

    // One full run; noise adds stray start and op_done pulses while busy
    task automatic run_case(input string name, input scalar_t s, input int mode, input bit noise);
        int cycles;
        int errs_before;
        errs_before = errors + chk_errors;
        test_name   = name;
        delay_mode  = mode;
        build_expected(s);
        scalar <= s;
        start  <= 1'b1;
        @(posedge clk);
        cycles = 0;
        while (!done && cycles < RUN_LIMIT) begin
            start     <= noise && (cycles % 37 == 5);
            spur_done <= noise && cycles >= 3 && cycles <= 60 && (cycles % 9 == 0);
            scalar    <= noise ? random_scalar() : s;
            @(posedge clk);
            cycles++;
        end
        start     <= 1'b0;
        spur_done <= 1'b0;
        assert (cycles < RUN_LIMIT) else begin
            $display("%s: no done within %0d cycles", name, RUN_LIMIT);
            errors++;
        end
        if (cycles >= RUN_LIMIT) begin
            reset <= 1'b0;             // Recover a stuck DUT for the next test
            repeat (2) @(posedge clk);
            reset <= 1'b1;
        end
        repeat (6) @(posedge clk);     // Room for a second done pulse
        assert (done_cnt == 1) else begin
            $display("ERR %s done pulses: expected 1, actual %0d", name, done_cnt);
            errors++;
        end
        assert (cmd_cnt == n_exp) else begin
            $display("ERR %s commands: expected %0d, actual %0d", name, n_exp, cmd_cnt);
            errors++;
        end
        assert (!busy) else begin
            $display("%s: busy still high after done", name);
            errors++;
        end
        report(name, errs_before);
    endtask

    task automatic reset_mid_run();
        int      cycles;
        int      seen;
        int      errs_before;
        scalar_t s;
        errs_before = errors + chk_errors;
        test_name   = "reset_mid_run";
        delay_mode  = 0;
        s           = random_scalar();
        build_expected(s);
        scalar <= s;
        start  <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        seen   = 0;
        cycles = 0;
        while (seen < 40 && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (op_valid) begin
                seen++;
            end
        end
        assert (seen == 40) else begin
            $display("reset_mid_run: run stalled before command 40");
            errors++;
        end
        reset <= 1'b0;
        repeat (3) @(posedge clk);
        assert (!op_valid && !busy && !done) else begin
            $display("ERR reset_mid_run valid/busy/done: expected 000, actual %b%b%b",
                     op_valid, busy, done);
            errors++;
        end
        reset <= 1'b1;
        @(posedge clk);
        report("reset_mid_run", errs_before);
        run_case("after_reset", random_scalar(), 0, 1'b0);
    endtask

    initial begin
        void'($urandom(91696));
        reset      = 1'b0;
        start      = 1'b0;
        scalar     = '0;
        spur_done  = 1'b0;
        delay_mode = 0;
        test_name  = "reset";
        n_exp      = 0;
        chk_errors = 0;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        for (int t = 0; t < 20; t++) begin
            run_case($sformatf("random_%0d", t), random_scalar(), 0, 1'b0);
        end
        run_case("zero", '0, 0, 1'b0);
        // Top nibble 7 keeps bit 255 clear while the carry runs through
        run_case("all_eights", {4'h7, {(N_DIGITS-1){4'h8}}}, 0, 1'b0);
        run_case("max_scalar", {1'b0, {($bits(scalar_t)-1){1'b1}}}, 0, 1'b0);
        run_case("zero_delay", random_scalar(), 1, 1'b0);
        run_case("long_delay", random_scalar(), 2, 1'b0);
        run_case("busy_noise", random_scalar(), 0, 1'b1);
        reset_mid_run();
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors + chk_errors);
        if (errors + chk_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src/scalarmult_sched_top.sv */
`timescale 1ns/1ns

module scalarmult_sched_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  ed_sched_pkg::scalar_t scalar,
    input  logic                  op_done,
    output logic                  op_valid,
    output ed_sched_pkg::op_t     op,
    output ed_sched_pkg::pos_t    op_pos,
    output ed_sched_pkg::digit_t  op_digit,
    output logic                  busy,
    output logic                  done
);
    import ed_sched_pkg::*;

    logic         start_accept;
    logic         recode_done;
    logic         wr_en;
    digit_index_t wr_index;
    digit_t       wr_digit;
    digit_index_t rd_index;
    digit_t       rd_digit;

    assign start_accept = start && !busy;   // Start during a run is dropped

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy <= 1'b0;
        end else if (start_accept) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    scalar_recoder i_recoder (
        .clk         (clk),
        .reset       (reset),
        .start       (start_accept),
        .scalar      (scalar),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_digit    (wr_digit),
        .recode_done (recode_done)
    );

    digit_bank i_bank (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_digit (wr_digit),
        .rd_index (rd_index),
        .rd_digit (rd_digit)
    );

    ladder_sequencer i_sequencer (
        .clk         (clk),
        .reset       (reset),
        .recode_done (recode_done),
        .op_done     (op_done),
        .rd_index    (rd_index),
        .rd_digit    (rd_digit),
        .op_valid    (op_valid),
        .op          (op),
        .op_pos      (op_pos),
        .op_digit    (op_digit),
        .done        (done)
    );

endmodule

/* src/ladder_sequencer.sv */
`timescale 1ns/1ns

module ladder_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       recode_done,
    input  logic                       op_done,
    output ed_sched_pkg::digit_index_t rd_index,
    input  ed_sched_pkg::digit_t       rd_digit,
    output logic                       op_valid,
    output ed_sched_pkg::op_t          op,
    output ed_sched_pkg::pos_t         op_pos,
    output ed_sched_pkg::digit_t       op_digit,
    output logic                       done
);
    import ed_sched_pkg::*;

    // Each command has an issue state and a wait state
    typedef enum logic [4:0] {
        IDLE,
        NEUTRAL,
        NEUTRAL_WAIT,
        ODD_MADD,
        ODD_MADD_WAIT,
        ODD_P3,
        ODD_P3_WAIT,
        DBL,            // P3_DBL first time, P2_DBL after
        DBL_WAIT,
        DBL_P2,
        DBL_P2_WAIT,
        DBL_P3,
        DBL_P3_WAIT,
        EVEN_MADD,
        EVEN_MADD_WAIT,
        EVEN_P3,
        EVEN_P3_WAIT,
        FINISH
    } state_t;

    state_t       state;
    state_t       next_state;
    digit_index_t idx;          // Index of the last MADD issued
    logic [2:0]   dbl_cnt;      // Doublings issued so far
    logic         pending;      // Command out, no op_done yet
    op_t          next_op;
    logic         issue_next;

    always_comb begin
        next_state = state;
        rd_index   = idx;
        case (state)
            IDLE:           next_state = recode_done ? NEUTRAL : IDLE;
            NEUTRAL:        next_state = NEUTRAL_WAIT;
            NEUTRAL_WAIT: begin
                rd_index   = digit_index_t'(1);    // First odd digit
                next_state = op_done ? ODD_MADD : NEUTRAL_WAIT;
            end
            ODD_MADD:       next_state = ODD_MADD_WAIT;
            ODD_MADD_WAIT:  next_state = op_done ? ODD_P3 : ODD_MADD_WAIT;
            ODD_P3:         next_state = ODD_P3_WAIT;
            ODD_P3_WAIT: begin
                rd_index = idx + digit_index_t'(2);
                if (op_done) begin
                    next_state = (idx == digit_index_t'(N_DIGITS - 1)) ? DBL : ODD_MADD;
                end
            end
            DBL:            next_state = DBL_WAIT;
            DBL_WAIT: begin
                if (op_done) begin
                    next_state = (dbl_cnt == 3'(N_DOUBLINGS)) ? DBL_P3 : DBL_P2;
                end
            end
            DBL_P2:         next_state = DBL_P2_WAIT;
            DBL_P2_WAIT:    next_state = op_done ? DBL : DBL_P2_WAIT;
            DBL_P3:         next_state = DBL_P3_WAIT;
            DBL_P3_WAIT: begin
                rd_index   = '0;                    // Even pass starts at digit 0
                next_state = op_done ? EVEN_MADD : DBL_P3_WAIT;
            end
            EVEN_MADD:      next_state = EVEN_MADD_WAIT;
            EVEN_MADD_WAIT: next_state = op_done ? EVEN_P3 : EVEN_MADD_WAIT;
            EVEN_P3:        next_state = EVEN_P3_WAIT;
            EVEN_P3_WAIT: begin
                rd_index = idx + digit_index_t'(2);
                if (op_done) begin
                    next_state = (idx == digit_index_t'(N_DIGITS - 2)) ? FINISH : EVEN_MADD;
                end
            end
            FINISH:         next_state = IDLE;
            default:        next_state = IDLE;
        endcase
    end

    // Command for the issue state about to be entered
    always_comb begin
        next_op    = OP_TO_P3;
        issue_next = 1'b1;
        case (next_state)
            NEUTRAL:                 next_op = OP_SET_NEUTRAL;
            ODD_MADD, EVEN_MADD:     next_op = OP_MADD;
            DBL:                     next_op = (dbl_cnt == '0) ? OP_P3_DBL : OP_P2_DBL;
            DBL_P2:                  next_op = OP_TO_P2;
            ODD_P3, DBL_P3, EVEN_P3: next_op = OP_TO_P3;
            default:                 issue_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= IDLE;
            idx      <= '0;
            dbl_cnt  <= '0;
            pending  <= 1'b0;
            op       <= OP_SET_NEUTRAL;
            op_pos   <= '0;
            op_digit <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE) begin
                dbl_cnt <= '0;
            end else if (state == DBL) begin
                dbl_cnt <= dbl_cnt + 1'b1;
            end
            if (issue_next) begin
                op       <= next_op;
                op_pos   <= '0;
                op_digit <= '0;
                if (next_op == OP_MADD) begin
                    idx      <= rd_index;
                    op_pos   <= rd_index[$bits(digit_index_t)-1:1];
                    op_digit <= rd_digit;
                end
            end
            if (op_valid) begin
                pending <= 1'b1;
            end else if (op_done) begin
                pending <= 1'b0;
            end
        end
    end

    assign op_valid = (state inside {NEUTRAL, ODD_MADD, ODD_P3, DBL, DBL_P2, DBL_P3,
                                     EVEN_MADD, EVEN_P3});
    assign done     = (state == FINISH);

    // The point unit sees one command at a time
    one_outstanding: assert property (
        @(posedge clk) disable iff (!reset)
        op_valid |-> !pending
    ) else $error("ladder_sequencer: op_valid while a command is outstanding");

endmodule

/* src/digit_bank.sv */
`timescale 1ns/1ns

module digit_bank (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wr_en,
    input  ed_sched_pkg::digit_index_t wr_index,
    input  ed_sched_pkg::digit_t       wr_digit,
    input  ed_sched_pkg::digit_index_t rd_index,
    output ed_sched_pkg::digit_t       rd_digit
);
    import ed_sched_pkg::*;

    digit_t bank [N_DIGITS];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int j = 0; j < N_DIGITS; j++) begin
                bank[j] <= '0;
            end
        end else if (wr_en) begin
            bank[wr_index] <= wr_digit;
        end
    end

    assign rd_digit = bank[rd_index];   // Sequencer samples in the same cycle

    // Recoder output must stay inside the table range
    digit_in_range: assert property (
        @(posedge clk) disable iff (!reset)
        wr_en |-> (wr_digit >= -8 && wr_digit <= 8)
    ) else $error("digit_bank: digit %0d out of range at index %0d", wr_digit, wr_index);

endmodule

/* src/scalar_recoder.sv */
`timescale 1ns/1ns

module scalar_recoder (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  ed_sched_pkg::scalar_t      scalar,
    output logic                       wr_en,
    output ed_sched_pkg::digit_index_t wr_index,
    output ed_sched_pkg::digit_t       wr_digit,
    output logic                       recode_done
);
    import ed_sched_pkg::*;

    scalar_t           shreg;      // Remaining nibbles, next one at the bottom
    logic              carry;
    logic              active;
    digit_index_t      idx;
    logic              last;       // Top digit, no reduction
    logic [NIBBLE_W:0] sum;
    logic              carry_out;

    assign last      = (idx == digit_index_t'(N_DIGITS - 1));
    assign sum       = {1'b0, shreg[NIBBLE_W-1:0]} + {{NIBBLE_W{1'b0}}, carry};
    assign carry_out = !last && (sum >= 5'd8);

    assign wr_en    = active;
    assign wr_index = idx;

    // Sums of 8 and above fold to sum - 16 and push one into the next digit
    always_comb begin
        if (carry_out) begin
            wr_digit = digit_t'(sum - 5'd16);
        end else begin
            wr_digit = digit_t'(sum);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            active      <= 1'b0;
            carry       <= 1'b0;
            idx         <= '0;
            recode_done <= 1'b0;
        end else begin
            recode_done <= 1'b0;
            if (start) begin
                active <= 1'b1;
                carry  <= 1'b0;
                idx    <= '0;
            end else if (active) begin
                carry <= carry_out;
                idx   <= idx + 1'b1;
                if (last) begin
                    active      <= 1'b0;
                    recode_done <= 1'b1;   // Cycle after digit 63 is written
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shreg <= scalar;
        end else if (active) begin
            shreg <= shreg >> NIBBLE_W;
        end
    end

    // A set top bit would push digit 63 past +8
    scalar_top_clear: assert property (
        @(posedge clk) disable iff (!reset)
        start |-> !scalar[$bits(scalar_t)-1]
    ) else $error("scalar_recoder: scalar top bit set at start");

endmodule

/* src/ed_sched_pkg.sv */
package ed_sched_pkg;

    localparam int N_DIGITS    = 64;   // Signed radix-16 digits per scalar
    localparam int NIBBLE_W    = 4;
    localparam int N_DOUBLINGS = 4;    // Between odd and even passes

    // Neutral, odd pass, doubling chain with conversions, even pass
    localparam int N_COMMANDS  = 1 + N_DIGITS + 2 * N_DOUBLINGS + N_DIGITS;

    typedef logic [N_DIGITS*NIBBLE_W-1:0] scalar_t;

    // One bit wider than a nibble to hold -8 .. +8
    typedef logic signed [NIBBLE_W:0] digit_t;

    typedef logic [$clog2(N_DIGITS)-1:0] digit_index_t;
    typedef logic [$clog2(N_DIGITS)-2:0] pos_t;    // Table row, index / 2

    // Commands to the point unit
    typedef enum logic [2:0] {
        OP_SET_NEUTRAL = 3'd0,
        OP_MADD        = 3'd1,   // Mixed add with table entry
        OP_P3_DBL      = 3'd2,
        OP_P2_DBL      = 3'd3,
        OP_TO_P2       = 3'd4,   // p1p1 to projective
        OP_TO_P3       = 3'd5    // p1p1 to extended
    } op_t;

endpackage
